//--- verilog/arb_tree_pkg.sv
// Widths and master count are fixed here, and N_MASTER must be a power of two of at least 4
package arb_tree_pkg;

    ////////////////////////////////////////
    // Tree size
    ////////////////////////////////////////

    // Number of requesting masters
    localparam int N_MASTER   = 8;

    // Width of a master index and of the priority flag
    localparam int LOG_MASTER = $clog2(N_MASTER);

    // Links between node levels, leaf and root links not counted
    localparam int N_LINK     = N_MASTER - 2;

    ////////////////////////////////////////
    // Request payload
    ////////////////////////////////////////

    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;
    localparam int ID_WIDTH   = 8;

    // Master index, also used for the round robin flag
    typedef logic [LOG_MASTER-1:0] master_idx_t;

    // Everything a master hands to the memory port, 57 bits with the default widths
    typedef struct packed
    {
        // Word address
        logic [ADDR_WIDTH-1:0] add;
        // Write enable
        logic                  wen;
        // Write data
        logic [DATA_WIDTH-1:0] wdata;
        // Byte enables
        logic [BE_WIDTH-1:0]   be;
        // Transaction ID, returned unchanged to the master
        logic [ID_WIDTH-1:0]   id;
    } req_payload_t;

endpackage

//--- verilog/arb_link_if.sv
// One req/gnt link between tree levels, where a transfer happens when req and gnt are both high
interface arb_link_if;

    import arb_tree_pkg::*;

    // Request level, held by the source until granted
    logic         req;

    // Grant level, returned by the sink in the same cycle
    logic         gnt;

    // Payload of the master currently presented
    req_payload_t payload;

    // Index of the master currently presented
    master_idx_t  idx;

    ////////////////////////////////////////
    // Modports
    ////////////////////////////////////////

    // Output side of a child node
    modport upstream
    (
        output req,
        output payload,
        output idx,
        input  gnt
    );

    // Input side of a parent node
    modport downstream
    (
        input  req,
        input  payload,
        input  idx,
        output gnt
    );

endinterface

//--- verilog/fan_in_node.sv
// Purely combinational two-input node, and LEVEL must stay below LOG_MASTER
module fan_in_node
#(
    parameter int LEVEL = 0
)
(
    // Flag bit for this level, 1 favours input 1 on a conflict
    input logic             prio_i,

    arb_link_if.downstream  in0,
    arb_link_if.downstream  in1,
    arb_link_if.upstream    out
);

    import arb_tree_pkg::*;

    // Selected side, 0 for in0 and 1 for in1
    logic sel;

    ////////////////////////////////////////
    // Selection
    ////////////////////////////////////////

    // A lone request wins, a conflict goes by the flag bit
    // With no request at all in0 stays selected
    assign sel = in1.req & (~in0.req | prio_i);

    assign out.req     = in0.req | in1.req;
    assign out.payload = sel ? in1.payload : in0.payload;

    ////////////////////////////////////////
    // Grant routing
    ////////////////////////////////////////

    // Only the selected side sees the grant
    // in0 is also qualified by its own request, since sel idles at 0
    assign in0.gnt = out.gnt & ~sel & in0.req;
    assign in1.gnt = out.gnt & sel;

    ////////////////////////////////////////
    // Index extension
    ////////////////////////////////////////

    generate
        if (LEVEL == 0)
        begin : g_leaf_idx
            // Leaves know their masters only by side
            assign out.idx = master_idx_t'(sel);
        end
        else
        begin : g_inner_idx
            master_idx_t low_idx;
            master_idx_t idx_ext;

            // Index from the child on the selected side
            assign low_idx = sel ? in1.idx : in0.idx;

            always_comb
            begin
                idx_ext = '0;
                // Lower bits come from the child, bits above LEVEL stay zero
                for (int b = 0; b < LEVEL; b++)
                begin
                    idx_ext[b] = low_idx[b];
                end
                idx_ext[LEVEL] = sel;
            end

            assign out.idx = idx_ext;
        end
    endgenerate

endmodule

//--- verilog/rr_flag_reg.sv
// Round robin flag, cleared by synchronous reset and moved only by a granted transfer
module rr_flag_reg
(
    input  logic                      clk,
    input  logic                      rst_i,

    // Root request and grant of the tree
    input  logic                      req_i,
    input  logic                      gnt_i,

    // Index of the master at the root in this cycle
    input  arb_tree_pkg::master_idx_t win_idx_i,

    // Priority flag, bit L steers level L
    output arb_tree_pkg::master_idx_t flag_o
);

    import arb_tree_pkg::*;

    master_idx_t flag_q;
    master_idx_t flag_d;

    // Transfer at the memory port in this cycle
    logic        xfer;

    assign xfer = req_i & gnt_i;

    ////////////////////////////////////////
    // Next flag
    ////////////////////////////////////////

    always_comb
    begin
        flag_d = flag_q;
        if (xfer)
        begin
            // Master after the winner gets the next conflict, wraps at N_MASTER
            flag_d = win_idx_i + master_idx_t'(1);
        end
    end

    ////////////////////////////////////////
    // Flag register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            flag_q <= '0;
        end
        else
        begin
            flag_q <= flag_d;
        end
    end

    assign flag_o = flag_q;

endmodule

//--- verilog/arb_tree.sv
// Grant based round robin tree with no registered outputs, masters hold req and payload until granted
module arb_tree
(
    input  logic                                               clk,
    input  logic                                               rst_i,

    // Master side
    input  logic                [arb_tree_pkg::N_MASTER-1:0]   data_req_i,
    input  arb_tree_pkg::req_payload_t [arb_tree_pkg::N_MASTER-1:0] data_payload_i,
    output logic                [arb_tree_pkg::N_MASTER-1:0]   data_gnt_o,

    // Memory side
    output logic                                               data_req_o,
    output arb_tree_pkg::req_payload_t                         data_payload_o,
    input  logic                                               data_gnt_i
);

    import arb_tree_pkg::*;

    // Round robin flag
    master_idx_t flag;

    ////////////////////////////////////////
    // Links
    ////////////////////////////////////////

    // One link per master into the leaf nodes
    arb_link_if leaf_link [N_MASTER-1:0] ();

    // Links between levels, level L outputs start at N_MASTER - (N_MASTER >> L)
    arb_link_if node_link [N_LINK-1:0] ();

    // Root output toward memory
    arb_link_if root_link ();

    ////////////////////////////////////////
    // Master ports
    ////////////////////////////////////////

    generate
        for (genvar m = 0; m < N_MASTER; m++)
        begin : g_master
            assign leaf_link[m].req     = data_req_i[m];
            assign leaf_link[m].payload = data_payload_i[m];
            assign data_gnt_o[m]        = leaf_link[m].gnt;
        end
    endgenerate

    ////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////

    assign data_req_o     = root_link.req;
    assign data_payload_o = root_link.payload;
    assign root_link.gnt  = data_gnt_i;

    ////////////////////////////////////////
    // Node tree
    ////////////////////////////////////////

    // Level 0 sits at the masters, level LOG_MASTER-1 is the single root
    generate
        for (genvar lvl = 0; lvl < LOG_MASTER; lvl++)
        begin : g_level
            for (genvar k = 0; k < (N_MASTER >> (lvl + 1)); k++)
            begin : g_node
                if (lvl == 0)
                begin : g_leaf
                    fan_in_node
                    #(
                        .LEVEL  ( lvl                 )
                    )
                    u_node
                    (
                        .prio_i ( flag[lvl]           ),
                        .in0    ( leaf_link[2*k]      ),
                        .in1    ( leaf_link[2*k+1]    ),
                        .out    ( node_link[k]        )
                    );
                end
                else if (lvl < LOG_MASTER - 1)
                begin : g_middle
                    fan_in_node
                    #(
                        .LEVEL  ( lvl )
                    )
                    u_node
                    (
                        .prio_i ( flag[lvl] ),
                        .in0    ( node_link[N_MASTER - (N_MASTER >> (lvl - 1)) + 2*k]     ),
                        .in1    ( node_link[N_MASTER - (N_MASTER >> (lvl - 1)) + 2*k + 1] ),
                        .out    ( node_link[N_MASTER - (N_MASTER >> lvl) + k]             )
                    );
                end
                else
                begin : g_root
                    // Inputs are the two outputs of the level below
                    fan_in_node
                    #(
                        .LEVEL  ( lvl )
                    )
                    u_node
                    (
                        .prio_i ( flag[lvl] ),
                        .in0    ( node_link[N_MASTER - (N_MASTER >> (lvl - 1))]     ),
                        .in1    ( node_link[N_MASTER - (N_MASTER >> (lvl - 1)) + 1] ),
                        .out    ( root_link                                         )
                    );
                end
            end
        end
    endgenerate

    ////////////////////////////////////////
    // Priority flag
    ////////////////////////////////////////

    // Moves past the root winner after each granted transfer
    rr_flag_reg u_flag
    (
        .clk       ( clk           ),
        .rst_i     ( rst_i         ),
        .req_i     ( root_link.req ),
        .gnt_i     ( data_gnt_i    ),
        .win_idx_i ( root_link.idx ),
        .flag_o    ( flag          )
    );

endmodule

//--- verification/tb_arb_tree.sv
// Seeded random stimulus, checked each cycle against a behavioral model, assumes N_MASTER <= 64
module tb_arb_tree;

    timeunit 1ns;
    timeprecision 1ps;

    import arb_tree_pkg::*;

    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 5;
    localparam int          SINGLE_ROUNDS = 60;
    localparam int          STALL_ROUNDS  = 30;
    localparam int          RANDOM_CYCLES = 1000;
    // All phases take about 1400 cycles at most
    localparam int          MAX_CYCLES    = 2000;
    localparam logic [31:0] SEED          = 32'hbfca_60b9;

    logic                        clk;
    logic                        rst_i;
    logic [N_MASTER-1:0]         data_req_i;
    req_payload_t [N_MASTER-1:0] data_payload_i;
    logic [N_MASTER-1:0]         data_gnt_o;
    logic                        data_req_o;
    req_payload_t                data_payload_o;
    logic                        data_gnt_i;

    // Model state and what the last cycle showed
    master_idx_t                 model_flag;
    master_idx_t                 last_win;
    logic [N_MASTER-1:0]         last_gnt;
    logic [N_MASTER-1:0]         obs_gnt;
    req_payload_t                obs_payload;
    int                          cycle_count;

    arb_tree dut
    (
        .clk            ( clk            ),
        .rst_i          ( rst_i          ),
        .data_req_i     ( data_req_i     ),
        .data_payload_i ( data_payload_i ),
        .data_gnt_o     ( data_gnt_o     ),
        .data_req_o     ( data_req_o     ),
        .data_payload_o ( data_payload_o ),
        .data_gnt_i     ( data_gnt_i     )
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic req_payload_t random_payload();
        req_payload_t p;
        p.add   = ADDR_WIDTH'($urandom);
        p.wen   = 1'($urandom);
        p.wdata = DATA_WIDTH'($urandom);
        p.be    = BE_WIDTH'($urandom);
        p.id    = ID_WIDTH'($urandom);
        return p;
    endfunction

    // Applies the node rule level by level, leaves first
    function automatic void model_arbitrate(input logic [N_MASTER-1:0] req,
                                            input master_idx_t flg,
                                            output logic any, output master_idx_t win);
        logic node_req [N_MASTER];
        int   node_idx [N_MASTER];
        int   width;
        logic take_in1;
        for (int m = 0; m < N_MASTER; m++)
        begin
            node_req[m] = req[m];
            node_idx[m] = m;
        end
        width = N_MASTER;
        for (int lvl = 0; lvl < LOG_MASTER; lvl++)
        begin
            // Node k of this level reads slots 2k and 2k+1, so overwriting slot k is safe
            for (int k = 0; k < width / 2; k++)
            begin
                if (node_req[2*k] && node_req[2*k+1])
                    take_in1 = flg[lvl];
                else
                    take_in1 = node_req[2*k+1];
                node_req[k] = node_req[2*k] | node_req[2*k+1];
                node_idx[k] = take_in1 ? node_idx[2*k+1] : node_idx[2*k];
            end
            width = width / 2;
        end
        any = node_req[0];
        win = master_idx_t'(node_idx[0]);
    endfunction

    // Checks outputs mid cycle, then follows the flag across the rising edge
    task automatic run_cycle();
        logic                exp_any;
        master_idx_t         exp_win;
        logic [N_MASTER-1:0] exp_gnt;
        @(negedge clk);
        model_arbitrate(data_req_i, model_flag, exp_any, exp_win);
        exp_gnt = '0;
        if (exp_any && data_gnt_i)
            exp_gnt[exp_win] = 1'b1;
        check_value("data_req_o", 64'(exp_any), 64'(data_req_o));
        check_value("data_gnt_o", 64'(exp_gnt), 64'(data_gnt_o));
        if (exp_any)
            check_value("data_payload_o", 64'(data_payload_i[exp_win]), 64'(data_payload_o));
        last_win    = exp_win;
        last_gnt    = exp_gnt;
        obs_gnt     = data_gnt_o;
        obs_payload = data_payload_o;
        @(posedge clk);
        if (rst_i)
            model_flag = '0;
        else if (exp_gnt != '0)
            model_flag = master_idx_t'((int'(exp_win) + 1) % N_MASTER);
        #1;
    endtask

    // Granted masters drop out or bring new data, idle masters join now and then
    task automatic advance_masters();
        for (int m = 0; m < N_MASTER; m++)
        begin
            if (last_gnt[m])
            begin
                if ($urandom_range(1, 0) == 0)
                    data_req_i[m] = 1'b0;
                else
                    data_payload_i[m] = random_payload();
            end
            else if (!data_req_i[m] && $urandom_range(2, 0) == 0)
            begin
                data_req_i[m]     = 1'b1;
                data_payload_i[m] = random_payload();
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int                  pick;
        int                  stretch;
        req_payload_t        held_payload;
        master_idx_t         held_win;
        logic [N_MASTER-1:0] exp_vec;

        void'($urandom(SEED));
        cycle_count    = 0;
        model_flag     = '0;
        rst_i          = 1'b1;
        data_req_i     = '0;
        data_payload_i = '0;
        data_gnt_i     = 1'b1;

        // Reset with no requests and the port open, nothing may be granted
        for (int c = 0; c < RESET_CYCLES; c++)
            run_cycle();
        rst_i = 1'b0;
        run_cycle();
        run_cycle();

        // Flag starts at 0, so master 0 wins a full conflict
        for (int m = 0; m < N_MASTER; m++)
            data_payload_i[m] = random_payload();
        data_req_i = '1;
        run_cycle();
        check_value("data_gnt_o", 64'(1), 64'(obs_gnt));
        data_req_i = '0;

        // One master at a time
        for (int r = 0; r < SINGLE_ROUNDS; r++)
        begin
            pick                 = $urandom_range(N_MASTER - 1, 0);
            data_req_i           = '0;
            data_req_i[pick]     = 1'b1;
            data_payload_i[pick] = random_payload();
            run_cycle();
            exp_vec       = '0;
            exp_vec[pick] = 1'b1;
            check_value("data_gnt_o", 64'(exp_vec), 64'(obs_gnt));
            check_value("data_payload_o", 64'(data_payload_i[pick]), 64'(obs_payload));
        end

        // Grant master 0 alone so the rotation starts at master 1
        data_req_i    = '0;
        data_req_i[0] = 1'b1;
        run_cycle();
        data_req_i = '1;
        for (int r = 0; r < 2 * N_MASTER; r++)
        begin
            run_cycle();
            exp_vec                       = '0;
            exp_vec[(r + 1) % N_MASTER]   = 1'b1;
            check_value("data_gnt_o", 64'(exp_vec), 64'(obs_gnt));
            data_payload_i[last_win] = random_payload();
        end

        ////////////////////////////////////////
        // Back-pressure stretches
        ////////////////////////////////////////

        for (int m = 0; m < N_MASTER; m++)
            data_req_i[m] = 1'($urandom);
        for (int s = 0; s < STALL_ROUNDS; s++)
        begin
            if (data_req_i == '0)
            begin
                pick                 = $urandom_range(N_MASTER - 1, 0);
                data_req_i[pick]     = 1'b1;
                data_payload_i[pick] = random_payload();
            end
            stretch    = $urandom_range(8, 1);
            data_gnt_i = 1'b0;
            run_cycle();
            held_win     = last_win;
            held_payload = data_payload_i[held_win];
            check_value("data_gnt_o", 64'(0), 64'(obs_gnt));
            for (int c = 1; c < stretch; c++)
            begin
                run_cycle();
                check_value("data_gnt_o", 64'(0), 64'(obs_gnt));
                check_value("data_payload_o", 64'(held_payload), 64'(obs_payload));
            end
            // The held winner takes the grant once the port opens
            data_gnt_i = 1'b1;
            run_cycle();
            exp_vec           = '0;
            exp_vec[held_win] = 1'b1;
            check_value("data_gnt_o", 64'(exp_vec), 64'(obs_gnt));
            advance_masters();
        end

        // Fully random traffic
        for (int c = 0; c < RANDOM_CYCLES; c++)
        begin
            data_gnt_i = ($urandom_range(3, 0) != 0);
            run_cycle();
            advance_masters();
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- arb_tree.f
verilog/arb_tree_pkg.sv
verilog/arb_link_if.sv
verilog/fan_in_node.sv
verilog/rr_flag_reg.sv
verilog/arb_tree.sv
verification/tb_arb_tree.sv

//--- run.sh
#!/bin/sh
# Builds the arb_tree testbench with Verilator, runs it and judges the result from the log

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_arb_tree

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1
then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 --top-module "$TOP" -Mdir "$BUILD_DIR" -f arb_tree.f
status=$?
if [ $status -ne 0 ]
then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"

if grep -q "Test failed" "$LOG_FILE"
then
    echo "Simulation FAILED, see $LOG_FILE"
    exit 1
fi

if [ $status -ne 0 ]
then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without errors, see $LOG_FILE"
exit 0
